// ==== rtl/ob_pkg.sv ====
// book sizes and codes shared by the whole design
// BOOK_DEPTH must equal 2**SLOT_W and COUNT_W must hold BOOK_DEPTH itself
package ob_pkg;

    // book geometry
    localparam int NUM_STOCKS = 4;
    localparam int STOCK_W    = 2;
    localparam int BOOK_DEPTH = 8;
    localparam int SLOT_W     = 3;
    localparam int COUNT_W    = 4;

    // field widths
    localparam int QTY_W   = 16;
    localparam int PRICE_W = 32;
    localparam int ID_W    = 32;

    // i_order_type codes
    localparam logic [1:0] ORD_ADD     = 2'd0;
    localparam logic [1:0] ORD_CANCEL  = 2'd1;
    localparam logic [1:0] ORD_EXECUTE = 2'd2;
    localparam logic [1:0] ORD_NOP     = 2'd3;

    // bit positions in the per-side strobe vectors, same sense as i_trade_type
    localparam int SIDE_ASK = 0;
    localparam int SIDE_BID = 1;

    // best price reported for a side with no orders
    localparam logic [PRICE_W-1:0] EMPTY_BID = '0;
    localparam logic [PRICE_W-1:0] EMPTY_ASK = '1;

endpackage

// ==== rtl/best_price_tracker.sv ====
// running max (bid) or min (ask) over one rescan sweep, one best register per stock
// i_scan_first must come with the first i_scan_step of every sweep
`timescale 1ns/1ps

module best_price_tracker #(
    parameter bit IS_BID = 1'b1
) (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic                        i_scan_first,
    input  logic                        i_scan_step,
    input  logic                        i_scan_commit,
    input  logic                        i_scan_empty,
    input  logic [ob_pkg::STOCK_W-1:0]  i_view_stock,
    output logic [ob_pkg::PRICE_W-1:0]  o_best
);

    logic [ob_pkg::PRICE_W-1:0] best_reg [ob_pkg::NUM_STOCKS];
    logic [ob_pkg::PRICE_W-1:0] running;
    logic [ob_pkg::PRICE_W-1:0] cand;
    logic                       better;

    // candidate includes the price swept in this cycle
    always_comb begin
        better = IS_BID ? (i_price > running) : (i_price < running);
        cand   = (i_scan_first || better) ? i_price : running;
    end

    always_ff @(posedge i_clk) begin
        if (i_scan_step) begin
            running <= cand;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < ob_pkg::NUM_STOCKS; s++) begin
                best_reg[s] <= IS_BID ? ob_pkg::EMPTY_BID : ob_pkg::EMPTY_ASK;
            end
        end else if (i_scan_commit) begin
            best_reg[i_stock] <= cand;
        end else if (i_scan_empty) begin
            best_reg[i_stock] <= IS_BID ? ob_pkg::EMPTY_BID : ob_pkg::EMPTY_ASK;
        end
    end

    assign o_best = best_reg[i_view_stock];

endmodule

// ==== rtl/book_side.sv ====
// order storage for one side of every stock, kept packed from slot 0 upwards
// strobes are one-hot and range checked by the controller
`timescale 1ns/1ps

module book_side #(
    parameter bit IS_BID = 1'b1
) (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock,
    input  logic [ob_pkg::SLOT_W-1:0]   i_slot,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic [ob_pkg::QTY_W-1:0]    i_qty,
    input  logic [ob_pkg::ID_W-1:0]     i_order_id,
    input  logic                        i_add_en,
    input  logic                        i_dec_en,
    input  logic                        i_shift_en,
    input  logic                        i_drop_en,
    input  logic                        i_scan_first,
    input  logic                        i_scan_step,
    input  logic                        i_scan_commit,
    input  logic                        i_scan_empty,
    input  logic [ob_pkg::STOCK_W-1:0]  i_view_stock,
    output logic [ob_pkg::COUNT_W-1:0]  o_count,
    output logic                        o_match,
    output logic [ob_pkg::QTY_W-1:0]    o_slot_qty,
    output logic [ob_pkg::PRICE_W-1:0]  o_best
);

    // flat arrays addressed by {stock, slot}
    logic [ob_pkg::QTY_W-1:0]   qty_mem   [ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::PRICE_W-1:0] price_mem [ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::ID_W-1:0]    id_mem    [ob_pkg::NUM_STOCKS*ob_pkg::BOOK_DEPTH];
    logic [ob_pkg::COUNT_W-1:0] count     [ob_pkg::NUM_STOCKS];

    logic [ob_pkg::SLOT_W-1:0]          nx_slot;
    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W-1:0] rd_addr;
    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W-1:0] nx_addr;
    logic [ob_pkg::STOCK_W+ob_pkg::SLOT_W-1:0] wr_addr;

    assign nx_slot = i_slot + 1'b1;
    assign rd_addr = {i_stock, i_slot};
    assign nx_addr = {i_stock, nx_slot};
    // new orders go to the tail
    assign wr_addr = {i_stock, count[i_stock][ob_pkg::SLOT_W-1:0]};

    always_ff @(posedge i_clk) begin
        if (i_add_en) begin
            qty_mem[wr_addr]   <= i_qty;
            price_mem[wr_addr] <= i_price;
            id_mem[wr_addr]    <= i_order_id;
        end else if (i_dec_en) begin
            qty_mem[rd_addr] <= qty_mem[rd_addr] - i_qty;
        end else if (i_shift_en) begin
            // close the gap left by a removed order
            qty_mem[rd_addr]   <= qty_mem[nx_addr];
            price_mem[rd_addr] <= price_mem[nx_addr];
            id_mem[rd_addr]    <= id_mem[nx_addr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < ob_pkg::NUM_STOCKS; s++) begin
                count[s] <= '0;
            end
        end else if (i_add_en) begin
            count[i_stock] <= count[i_stock] + 1'b1;
        end else if (i_drop_en) begin
            count[i_stock] <= count[i_stock] - 1'b1;
        end
    end

    assign o_count    = count[i_stock];
    assign o_match    = (id_mem[rd_addr] == i_order_id);
    assign o_slot_qty = qty_mem[rd_addr];

    best_price_tracker #(
        .IS_BID (IS_BID)
    ) u_best (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_stock       (i_stock),
        .i_price       (price_mem[rd_addr]),
        .i_scan_first  (i_scan_first),
        .i_scan_step   (i_scan_step),
        .i_scan_commit (i_scan_commit),
        .i_scan_empty  (i_scan_empty),
        .i_view_stock  (i_view_stock),
        .o_best        (o_best)
    );

endmodule

// ==== rtl/order_ctrl.sv ====
// one command at a time, inputs latched on acceptance while idle
// busy stays high through the cycle in which o_data_valid pulses
`timescale 1ns/1ps

module order_ctrl (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_trade_type,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock_id,
    input  logic [1:0]                  i_order_type,
    input  logic [ob_pkg::QTY_W-1:0]    i_quantity,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic [ob_pkg::ID_W-1:0]     i_order_id,
    input  logic [ob_pkg::COUNT_W-1:0]  i_bid_count,
    input  logic [ob_pkg::COUNT_W-1:0]  i_ask_count,
    input  logic                        i_bid_match,
    input  logic                        i_ask_match,
    input  logic [ob_pkg::QTY_W-1:0]    i_bid_slot_qty,
    input  logic [ob_pkg::QTY_W-1:0]    i_ask_slot_qty,
    output logic [ob_pkg::STOCK_W-1:0]  o_stock,
    output logic [ob_pkg::SLOT_W-1:0]   o_slot,
    output logic [ob_pkg::PRICE_W-1:0]  o_price,
    output logic [ob_pkg::QTY_W-1:0]    o_qty,
    output logic [ob_pkg::ID_W-1:0]     o_order_id,
    output logic [1:0]                  o_add_en,
    output logic [1:0]                  o_dec_en,
    output logic [1:0]                  o_shift_en,
    output logic [1:0]                  o_drop_en,
    output logic [1:0]                  o_scan_first,
    output logic [1:0]                  o_scan_step,
    output logic [1:0]                  o_scan_commit,
    output logic [1:0]                  o_scan_empty,
    output logic                        o_book_is_busy,
    output logic                        o_data_valid,
    output logic                        o_cmd_ok
);

    enum logic [2:0] {S_IDLE, S_ADD, S_SEARCH, S_SHIFT, S_SCAN, S_DONE} state, next_state;

    // latched command
    logic                       side_r;
    logic [1:0]                 type_r;
    logic [ob_pkg::STOCK_W-1:0] stock_r;
    logic [ob_pkg::QTY_W-1:0]   qty_r;
    logic [ob_pkg::PRICE_W-1:0] price_r;
    logic [ob_pkg::ID_W-1:0]    id_r;

    // slot index, one wider than a slot so a search can reach the count
    logic [ob_pkg::COUNT_W-1:0] idx;
    logic [ob_pkg::COUNT_W-1:0] next_idx;
    logic                       ok_r;
    logic                       next_ok;

    logic [1:0]                 side_sel;
    logic [ob_pkg::COUNT_W-1:0] cur_count;
    logic                       cur_match;
    logic [ob_pkg::QTY_W-1:0]   cur_qty;
    logic add_en;
    logic dec_en;
    logic shift_en;
    logic drop_en;
    logic scan_first;
    logic scan_step;
    logic scan_commit;
    logic scan_empty;

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state <= S_IDLE;
            idx   <= '0;
            ok_r  <= 1'b0;
        end else begin
            state <= next_state;
            idx   <= next_idx;
            ok_r  <= next_ok;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == S_IDLE && i_order_type != ob_pkg::ORD_NOP) begin
            side_r  <= i_trade_type;
            type_r  <= i_order_type;
            stock_r <= i_stock_id;
            qty_r   <= i_quantity;
            price_r <= i_price;
            id_r    <= i_order_id;
        end
    end

    // feedback from the side named by the latched trade type
    always_comb begin
        side_sel[ob_pkg::SIDE_BID] = side_r;
        side_sel[ob_pkg::SIDE_ASK] = !side_r;
        cur_count = side_r ? i_bid_count : i_ask_count;
        cur_match = side_r ? i_bid_match : i_ask_match;
        cur_qty   = side_r ? i_bid_slot_qty : i_ask_slot_qty;
    end

    always_comb begin
        next_state  = state;
        next_idx    = idx;
        next_ok     = ok_r;
        add_en      = 1'b0;
        dec_en      = 1'b0;
        shift_en    = 1'b0;
        drop_en     = 1'b0;
        scan_first  = 1'b0;
        scan_step   = 1'b0;
        scan_commit = 1'b0;
        scan_empty  = 1'b0;
        case (state)
            S_IDLE: begin
                if (i_order_type != ob_pkg::ORD_NOP) begin
                    next_state = (i_order_type == ob_pkg::ORD_ADD) ? S_ADD : S_SEARCH;
                    next_idx   = '0;
                    next_ok    = 1'b0;
                end
            end
            S_ADD: begin
                if (cur_count == ob_pkg::BOOK_DEPTH[ob_pkg::COUNT_W-1:0]) begin
                    next_state = S_DONE;
                end else begin
                    add_en     = 1'b1;
                    next_ok    = 1'b1;
                    next_state = S_SCAN;
                end
            end
            S_SEARCH: begin
                if (idx == cur_count) begin
                    // id not held on this side
                    next_state = S_DONE;
                end else if (cur_match) begin
                    next_ok = 1'b1;
                    if (type_r == ob_pkg::ORD_EXECUTE && qty_r < cur_qty) begin
                        dec_en     = 1'b1;
                        next_idx   = '0;
                        next_state = S_SCAN;
                    end else begin
                        next_state = S_SHIFT;
                    end
                end else begin
                    next_idx = idx + 1'b1;
                end
            end
            S_SHIFT: begin
                if (idx + 1'b1 < cur_count) begin
                    shift_en = 1'b1;
                    next_idx = idx + 1'b1;
                end else begin
                    drop_en    = 1'b1;
                    next_idx   = '0;
                    next_state = S_SCAN;
                end
            end
            S_SCAN: begin
                if (cur_count == '0) begin
                    scan_empty = 1'b1;
                    next_state = S_DONE;
                end else begin
                    scan_step  = 1'b1;
                    scan_first = (idx == '0);
                    if (idx == cur_count - 1'b1) begin
                        scan_commit = 1'b1;
                        next_state  = S_DONE;
                    end else begin
                        next_idx = idx + 1'b1;
                    end
                end
            end
            S_DONE: begin
                next_state = S_IDLE;
            end
            default: begin
                next_state = S_IDLE;
            end
        endcase
    end

    assign o_stock    = stock_r;
    assign o_slot     = idx[ob_pkg::SLOT_W-1:0];
    assign o_price    = price_r;
    assign o_qty      = qty_r;
    assign o_order_id = id_r;

    assign o_add_en      = {2{add_en}} & side_sel;
    assign o_dec_en      = {2{dec_en}} & side_sel;
    assign o_shift_en    = {2{shift_en}} & side_sel;
    assign o_drop_en     = {2{drop_en}} & side_sel;
    assign o_scan_first  = {2{scan_first}} & side_sel;
    assign o_scan_step   = {2{scan_step}} & side_sel;
    assign o_scan_commit = {2{scan_commit}} & side_sel;
    assign o_scan_empty  = {2{scan_empty}} & side_sel;

    assign o_book_is_busy = (state != S_IDLE);
    assign o_data_valid   = (state == S_DONE);
    assign o_cmd_ok       = (state == S_DONE) && ok_r;

endmodule

// ==== rtl/order_book_top.sv ====
// limit order book for NUM_STOCKS stocks, one bid and one ask side each
// best prices follow i_stock_id combinationally and are current when o_data_valid is high
`timescale 1ns/1ps

module order_book_top (
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    input  logic                        i_trade_type,
    input  logic [ob_pkg::STOCK_W-1:0]  i_stock_id,
    input  logic [1:0]                  i_order_type,
    input  logic [ob_pkg::QTY_W-1:0]    i_quantity,
    input  logic [ob_pkg::PRICE_W-1:0]  i_price,
    input  logic [ob_pkg::ID_W-1:0]     i_order_id,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_bid,
    output logic [ob_pkg::PRICE_W-1:0]  o_best_ask,
    output logic                        o_book_is_busy,
    output logic                        o_data_valid,
    output logic                        o_cmd_ok
);

    logic [ob_pkg::STOCK_W-1:0] stock;
    logic [ob_pkg::SLOT_W-1:0]  slot;
    logic [ob_pkg::PRICE_W-1:0] price;
    logic [ob_pkg::QTY_W-1:0]   qty;
    logic [ob_pkg::ID_W-1:0]    order_id;

    // strobe vectors, bit SIDE_BID for the bid side and SIDE_ASK for the ask side
    logic [1:0] add_en;
    logic [1:0] dec_en;
    logic [1:0] shift_en;
    logic [1:0] drop_en;
    logic [1:0] scan_first;
    logic [1:0] scan_step;
    logic [1:0] scan_commit;
    logic [1:0] scan_empty;

    logic [ob_pkg::COUNT_W-1:0] bid_count;
    logic [ob_pkg::COUNT_W-1:0] ask_count;
    logic                       bid_match;
    logic                       ask_match;
    logic [ob_pkg::QTY_W-1:0]   bid_slot_qty;
    logic [ob_pkg::QTY_W-1:0]   ask_slot_qty;

    order_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_trade_type   (i_trade_type),
        .i_stock_id     (i_stock_id),
        .i_order_type   (i_order_type),
        .i_quantity     (i_quantity),
        .i_price        (i_price),
        .i_order_id     (i_order_id),
        .i_bid_count    (bid_count),
        .i_ask_count    (ask_count),
        .i_bid_match    (bid_match),
        .i_ask_match    (ask_match),
        .i_bid_slot_qty (bid_slot_qty),
        .i_ask_slot_qty (ask_slot_qty),
        .o_stock        (stock),
        .o_slot         (slot),
        .o_price        (price),
        .o_qty          (qty),
        .o_order_id     (order_id),
        .o_add_en       (add_en),
        .o_dec_en       (dec_en),
        .o_shift_en     (shift_en),
        .o_drop_en      (drop_en),
        .o_scan_first   (scan_first),
        .o_scan_step    (scan_step),
        .o_scan_commit  (scan_commit),
        .o_scan_empty   (scan_empty),
        .o_book_is_busy (o_book_is_busy),
        .o_data_valid   (o_data_valid),
        .o_cmd_ok       (o_cmd_ok)
    );

    book_side #(
        .IS_BID (1'b1)
    ) u_bid (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_stock       (stock),
        .i_slot        (slot),
        .i_price       (price),
        .i_qty         (qty),
        .i_order_id    (order_id),
        .i_add_en      (add_en[ob_pkg::SIDE_BID]),
        .i_dec_en      (dec_en[ob_pkg::SIDE_BID]),
        .i_shift_en    (shift_en[ob_pkg::SIDE_BID]),
        .i_drop_en     (drop_en[ob_pkg::SIDE_BID]),
        .i_scan_first  (scan_first[ob_pkg::SIDE_BID]),
        .i_scan_step   (scan_step[ob_pkg::SIDE_BID]),
        .i_scan_commit (scan_commit[ob_pkg::SIDE_BID]),
        .i_scan_empty  (scan_empty[ob_pkg::SIDE_BID]),
        .i_view_stock  (i_stock_id),
        .o_count       (bid_count),
        .o_match       (bid_match),
        .o_slot_qty    (bid_slot_qty),
        .o_best        (o_best_bid)
    );

    book_side #(
        .IS_BID (1'b0)
    ) u_ask (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_stock       (stock),
        .i_slot        (slot),
        .i_price       (price),
        .i_qty         (qty),
        .i_order_id    (order_id),
        .i_add_en      (add_en[ob_pkg::SIDE_ASK]),
        .i_dec_en      (dec_en[ob_pkg::SIDE_ASK]),
        .i_shift_en    (shift_en[ob_pkg::SIDE_ASK]),
        .i_drop_en     (drop_en[ob_pkg::SIDE_ASK]),
        .i_scan_first  (scan_first[ob_pkg::SIDE_ASK]),
        .i_scan_step   (scan_step[ob_pkg::SIDE_ASK]),
        .i_scan_commit (scan_commit[ob_pkg::SIDE_ASK]),
        .i_scan_empty  (scan_empty[ob_pkg::SIDE_ASK]),
        .i_view_stock  (i_stock_id),
        .o_count       (ask_count),
        .o_match       (ask_match),
        .o_slot_qty    (ask_slot_qty),
        .o_best        (o_best_ask)
    );

endmodule

// ==== test/tb_book_model.svh ====
// reference book model, included inside the testbench module
// one queue per stock and side, oldest order first, so a search finds the same order as the DUT
`ifndef TB_BOOK_MODEL_SVH
`define TB_BOOK_MODEL_SVH

localparam int NUM_BOOKS = ob_pkg::NUM_STOCKS * 2;

// book index is stock * 2 + side, side 1 for bids
logic [ob_pkg::PRICE_W-1:0] m_price [NUM_BOOKS][$];
logic [ob_pkg::QTY_W-1:0]   m_qty   [NUM_BOOKS][$];
logic [ob_pkg::ID_W-1:0]    m_id    [NUM_BOOKS][$];

// applies one command to the model and returns whether it succeeds
function automatic bit model_apply(input logic [1:0] typ, input logic side,
                                   input logic [ob_pkg::STOCK_W-1:0] stock,
                                   input logic [ob_pkg::QTY_W-1:0] qty,
                                   input logic [ob_pkg::PRICE_W-1:0] price,
                                   input logic [ob_pkg::ID_W-1:0] id);
    int b;
    b = int'(stock) * 2 + int'(side);
    if (typ == ob_pkg::ORD_ADD) begin
        if (m_id[b].size() >= ob_pkg::BOOK_DEPTH) begin
            return 1'b0;
        end
        m_price[b].push_back(price);
        m_qty[b].push_back(qty);
        m_id[b].push_back(id);
        return 1'b1;
    end
    for (int i = 0; i < m_id[b].size(); i++) begin
        if (m_id[b][i] == id) begin
            // partial execute keeps the order, anything else removes it
            if (typ == ob_pkg::ORD_EXECUTE && qty < m_qty[b][i]) begin
                m_qty[b][i] = m_qty[b][i] - qty;
            end else begin
                m_price[b].delete(i);
                m_qty[b].delete(i);
                m_id[b].delete(i);
            end
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// highest bid or lowest ask of one stock, or the empty value
function automatic logic [ob_pkg::PRICE_W-1:0] expected_best(
        input logic [ob_pkg::STOCK_W-1:0] stock, input logic side);
    int b;
    logic [ob_pkg::PRICE_W-1:0] best;
    b = int'(stock) * 2 + int'(side);
    best = side ? ob_pkg::EMPTY_BID : ob_pkg::EMPTY_ASK;
    for (int i = 0; i < m_price[b].size(); i++) begin
        if (side ? (m_price[b][i] > best) : (m_price[b][i] < best)) begin
            best = m_price[b][i];
        end
    end
    return best;
endfunction

`endif

// ==== test/tb_order_book.sv ====
// directed and random commands against a reference book model
// i_stock_id is held at the command's stock until o_data_valid so the best prices can be checked
`timescale 1ns/1ps

module tb_order_book;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_CMDS   = 20 + NUM_RANDOM;
    // reset and the idle best-price sweeps get a small margin on top
    localparam int WATCHDOG_CYCLES = 64 + NUM_CMDS * (3 * ob_pkg::BOOK_DEPTH + 4);

    logic                       i_clk;
    logic                       i_reset_n;
    logic                       i_trade_type;
    logic [ob_pkg::STOCK_W-1:0] i_stock_id;
    logic [1:0]                 i_order_type;
    logic [ob_pkg::QTY_W-1:0]   i_quantity;
    logic [ob_pkg::PRICE_W-1:0] i_price;
    logic [ob_pkg::ID_W-1:0]    i_order_id;
    logic [ob_pkg::PRICE_W-1:0] o_best_bid;
    logic [ob_pkg::PRICE_W-1:0] o_best_ask;
    logic                       o_book_is_busy;
    logic                       o_data_valid;
    logic                       o_cmd_ok;

    logic        exp_ok;
    logic [31:0] lfsr_state;

    `include "tb_book_model.svh"

    order_book_top dut0 (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_trade_type   (i_trade_type),
        .i_stock_id     (i_stock_id),
        .i_order_type   (i_order_type),
        .i_quantity     (i_quantity),
        .i_price        (i_price),
        .i_order_id     (i_order_id),
        .o_best_bid     (o_best_bid),
        .o_best_ask     (o_best_ask),
        .o_book_is_busy (o_book_is_busy),
        .o_data_valid   (o_data_valid),
        .o_cmd_ok       (o_cmd_ok)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val = {val[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return val;
    endfunction

    task automatic send_cmd(input logic [1:0] typ, input logic side,
                            input logic [ob_pkg::STOCK_W-1:0] stock,
                            input logic [ob_pkg::QTY_W-1:0] qty,
                            input logic [ob_pkg::PRICE_W-1:0] price,
                            input logic [ob_pkg::ID_W-1:0] id);
        @(negedge i_clk);
        while (o_book_is_busy) begin
            @(negedge i_clk);
        end
        i_order_type = typ;
        i_trade_type = side;
        i_stock_id   = stock;
        i_quantity   = qty;
        i_price      = price;
        i_order_id   = id;
        exp_ok       = model_apply(typ, side, stock, qty, price, id);
        @(negedge i_clk);
        i_order_type = ob_pkg::ORD_NOP;
        check_value("o_book_is_busy", 32'(o_book_is_busy), 32'd1);
        while (!o_data_valid) begin
            @(negedge i_clk);
        end
    endtask

    // sweeps i_stock_id over every stock while the book is idle
    task automatic check_all_stocks();
        for (int s = 0; s < ob_pkg::NUM_STOCKS; s++) begin
            @(negedge i_clk);
            i_stock_id = 2'(s);
            @(negedge i_clk);
            check_value("o_book_is_busy", 32'(o_book_is_busy), 32'd0);
            check_value("o_data_valid", 32'(o_data_valid), 32'd0);
            check_value("o_best_bid", o_best_bid, expected_best(2'(s), 1'b1));
            check_value("o_best_ask", o_best_ask, expected_best(2'(s), 1'b0));
        end
    endtask

    // result of every command is checked in its valid cycle
    always @(negedge i_clk) begin
        if (i_reset_n && o_data_valid) begin
            check_value("o_cmd_ok", 32'(o_cmd_ok), 32'(exp_ok));
            check_value("o_best_bid", o_best_bid, expected_best(i_stock_id, 1'b1));
            check_value("o_best_ask", o_best_ask, expected_best(i_stock_id, 1'b0));
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        $display("Timeout: the design hung and never finished its commands");
        $display("Verification failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [31:0]              rv;
        logic [1:0]               typ;
        logic                     side;
        logic [ob_pkg::STOCK_W-1:0] stock;
        logic [ob_pkg::QTY_W-1:0] qty;
        logic [ob_pkg::PRICE_W-1:0] price;
        logic [ob_pkg::ID_W-1:0]  id;

        lfsr_state   = 32'h20a835fb;
        exp_ok       = 1'b0;
        i_reset_n    = 1'b0;
        i_trade_type = 1'b0;
        i_stock_id   = '0;
        i_order_type = ob_pkg::ORD_NOP;
        i_quantity   = '0;
        i_price      = '0;
        i_order_id   = '0;
        repeat (4) @(negedge i_clk);
        i_reset_n = 1'b1;

        // empty books after reset
        check_all_stocks();

        // adds on stocks 0 and 2 while stocks 1 and 3 stay empty
        send_cmd(ob_pkg::ORD_ADD, 1'b1, 2'd0, 16'd10, 32'd100, 32'd1);
        send_cmd(ob_pkg::ORD_ADD, 1'b1, 2'd0, 16'd10, 32'd120, 32'd2);
        send_cmd(ob_pkg::ORD_ADD, 1'b1, 2'd0, 16'd10, 32'd110, 32'd3);
        send_cmd(ob_pkg::ORD_ADD, 1'b0, 2'd0, 16'd10, 32'd130, 32'd4);
        send_cmd(ob_pkg::ORD_ADD, 1'b0, 2'd0, 16'd10, 32'd125, 32'd5);
        send_cmd(ob_pkg::ORD_ADD, 1'b1, 2'd2, 16'd5, 32'd50, 32'd6);
        send_cmd(ob_pkg::ORD_ADD, 1'b0, 2'd2, 16'd5, 32'd60, 32'd7);
        check_all_stocks();

        // fill the bid side of stock 1 so the ninth add is rejected
        for (int k = 0; k <= ob_pkg::BOOK_DEPTH; k++) begin
            send_cmd(ob_pkg::ORD_ADD, 1'b1, 2'd1, 16'd1, 32'(200 + k), 32'(16 + k));
        end
        check_all_stocks();

        // cancel the best bid and then a missing id
        send_cmd(ob_pkg::ORD_CANCEL, 1'b1, 2'd0, 16'd0, 32'd0, 32'd2);
        send_cmd(ob_pkg::ORD_CANCEL, 1'b1, 2'd0, 16'd0, 32'd0, 32'd99);

        // partial then full execute of the best ask
        send_cmd(ob_pkg::ORD_EXECUTE, 1'b0, 2'd0, 16'd4, 32'd0, 32'd5);
        send_cmd(ob_pkg::ORD_EXECUTE, 1'b0, 2'd0, 16'd6, 32'd0, 32'd5);
        check_all_stocks();

        // small id range so cancels and executes often hit
        for (int r = 0; r < NUM_RANDOM; r++) begin
            rv    = rand_bits(2);
            typ   = (rv[1:0] == ob_pkg::ORD_NOP) ? ob_pkg::ORD_ADD : rv[1:0];
            rv    = rand_bits(1);
            side  = rv[0];
            rv    = rand_bits(2);
            stock = rv[1:0];
            rv    = rand_bits(3);
            qty   = 16'(rv[2:0]) + 16'd1;
            rv    = rand_bits(8);
            price = 32'(rv[7:0]) + 32'd1;
            rv    = rand_bits(4);
            id    = 32'(rv[3:0]);
            send_cmd(typ, side, stock, qty, price, id);
        end
        check_all_stocks();

        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+test
rtl/ob_pkg.sv
rtl/best_price_tracker.sv
rtl/book_side.sv
rtl/order_ctrl.sv
rtl/order_book_top.sv
test/tb_order_book.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the order book testbench with Verilator
cd "$(dirname "$0")" && \
verilator --binary --timing -f verilog.f --top-module tb_order_book -o tb_order_book && \
./obj_dir/tb_order_book | tee /dev/stderr | grep -F "Verification passed" > /dev/null && \
echo "PASS" || { echo "FAIL"; exit 1; }
